//--- logic/rv_pkg.sv
package rv_pkg;

    parameter int XLEN       = 64;
    parameter int ILEN       = 32;
    parameter int REG_ADDR_W = 5;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_branch = 7'b1100011,
        opc_store  = 7'b0100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic {
        alu_add = 1'b0,
        alu_sub = 1'b1
    } alu_op_e;

    typedef enum logic [1:0] {
        src_reg_reg = 2'd0,
        src_reg_imm = 2'd1,
        src_pc_four = 2'd2, // link value
        src_pc_imm  = 2'd3  // auipc
    } alu_src_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_sel_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        imm_sel_e              imm_sel;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        logic                  store;
        logic                  ebreak;
        logic                  illegal;
        logic [ILEN-1:7]       imm_bits; // inst[31:7]
    } id_ex_t;

    typedef struct packed {
        logic                  wen;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } wb_t;

    typedef struct packed {
        logic            take;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    input  wb_t                   wb,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    logic [XLEN-1:0] regs [1:31]; // x0 is not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // reads see a write of the same cycle
    always_comb begin
        if (raddr1 == '0)
            rdata1 = '0;
        else if (wb.wen && wb.waddr == raddr1)
            rdata1 = wb.wdata;
        else
            rdata1 = regs[raddr1];
    end

    always_comb begin
        if (raddr2 == '0)
            rdata2 = '0;
        else if (wb.wen && wb.waddr == raddr2)
            rdata2 = wb.wdata;
        else
            rdata2 = regs[raddr2];
    end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [ILEN-1:0] inst,
    input  redirect_t       redirect,
    input  logic            flush,
    input  logic            halt,
    output logic [XLEN-1:0] pc,
    output if_id_t          if_id
);

    logic [XLEN-1:0] pc_next;

    always_comb begin
        if (halt)
            pc_next = pc;              // frozen until reset
        else if (redirect.take)
            pc_next = redirect.target;
        else
            pc_next = pc + XLEN'(4);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch-to-decode register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else begin
            if_id.valid <= ~flush & ~halt; // squash wrong-path fetch
            if_id.pc    <= pc;
            if_id.inst  <= inst;
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  if_id_t if_id,
    input  wb_t    wb,
    input  logic   flush,
    output id_ex_t id_ex
);

    localparam logic [ILEN-1:0] EBREAK_INST = 32'h0010_0073;

    opcode_e               opc;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] raddr1;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    id_ex_t                ctl;

    assign opc    = opcode_e'(if_id.inst[6:0]);
    assign funct3 = if_id.inst[14:12];
    assign funct7 = if_id.inst[31:25];
    assign rd     = if_id.inst[11:7];
    assign rs1    = if_id.inst[19:15];
    assign rs2    = if_id.inst[24:20];

    assign raddr1 = (opc == opc_lui) ? '0 : rs1; // lui adds to x0

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (rs2),
        .wb     (wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_comb begin
        ctl          = '0;
        ctl.pc       = if_id.pc;
        ctl.rd       = rd;
        ctl.imm_bits = if_id.inst[ILEN-1:7];
        ctl.alu_op   = alu_add;
        ctl.alu_src  = src_reg_reg;
        ctl.imm_sel  = imm_i;
        case (opc)
            opc_op: begin
                ctl.reg_wen = 1'b1;
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    ctl.alu_op = alu_add;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000)
                    ctl.alu_op = alu_sub;
                else
                    ctl.illegal = 1'b1;
            end
            opc_op_imm: begin // addi only
                ctl.reg_wen = 1'b1;
                ctl.alu_src = src_reg_imm;
                ctl.illegal = (funct3 != 3'b000);
            end
            opc_branch: begin // bne only
                ctl.branch  = 1'b1;
                ctl.alu_op  = alu_sub;
                ctl.imm_sel = imm_b;
                ctl.illegal = (funct3 != 3'b001);
            end
            opc_store: begin // sd only
                ctl.store   = 1'b1;
                ctl.alu_src = src_reg_imm;
                ctl.imm_sel = imm_s;
                ctl.illegal = (funct3 != 3'b011);
            end
            opc_jal: begin
                ctl.jump    = 1'b1;
                ctl.reg_wen = 1'b1;
                ctl.alu_src = src_pc_four;
                ctl.imm_sel = imm_j;
            end
            opc_jalr: begin
                ctl.jump    = 1'b1;
                ctl.jalr    = 1'b1;
                ctl.reg_wen = 1'b1;
                ctl.alu_src = src_pc_four;
                ctl.illegal = (funct3 != 3'b000);
            end
            opc_lui: begin
                ctl.reg_wen = 1'b1;
                ctl.alu_src = src_reg_imm;
                ctl.imm_sel = imm_u;
            end
            opc_auipc: begin
                ctl.reg_wen = 1'b1;
                ctl.alu_src = src_pc_imm;
                ctl.imm_sel = imm_u;
            end
            opc_system: begin
                // ebreak is the only system encoding kept
                if (if_id.inst == EBREAK_INST)
                    ctl.ebreak = 1'b1;
                else
                    ctl.illegal = 1'b1;
            end
            default: ctl.illegal = 1'b1;
        endcase
    end

    // decode-to-execute register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex         <= ctl;
            id_ex.valid   <= if_id.valid & ~flush;
            id_ex.rs1_val <= rdata1;
            id_ex.rs2_val <= rdata2;
        end
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  id_ex_t          id_ex,
    output wb_t             wb,
    output redirect_t       redirect,
    output logic            flush,
    output logic            dmem_we,
    output logic [XLEN-1:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    output logic            halt,
    output logic            illegal
);

    logic [ILEN-1:0] ib;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] tgt_base;
    logic [XLEN-1:0] target;
    logic            act;
    logic            halting;
    logic            commit;
    logic            taken;

    assign ib = {id_ex.imm_bits, 7'b0}; // opcode bits not needed here

    always_comb begin
        case (id_ex.imm_sel)
            imm_s:   imm = {{52{ib[31]}}, ib[31:25], ib[11:7]};
            imm_b:   imm = {{51{ib[31]}}, ib[31], ib[7], ib[30:25], ib[11:8], 1'b0};
            imm_u:   imm = {{32{ib[31]}}, ib[31:12], 12'b0};
            imm_j:   imm = {{43{ib[31]}}, ib[31], ib[19:12], ib[20], ib[30:21], 1'b0};
            default: imm = {{52{ib[31]}}, ib[31:20]};
        endcase
    end

    always_comb begin
        case (id_ex.alu_src)
            src_reg_imm: begin
                op_a = id_ex.rs1_val;
                op_b = imm;
            end
            src_pc_four: begin
                op_a = id_ex.pc;
                op_b = XLEN'(4);
            end
            src_pc_imm: begin
                op_a = id_ex.pc;
                op_b = imm;
            end
            default: begin
                op_a = id_ex.rs1_val;
                op_b = id_ex.rs2_val;
            end
        endcase
    end

    assign alu_res = (id_ex.alu_op == alu_sub) ? op_a - op_b : op_a + op_b;

    assign taken    = id_ex.branch & (alu_res != '0); // bne: rs1 - rs2 nonzero
    assign tgt_base = id_ex.jalr ? id_ex.rs1_val : id_ex.pc;
    assign target   = (tgt_base + imm) & ~XLEN'(1);

    assign act     = id_ex.valid & ~halt;
    assign halting = act & (id_ex.ebreak | id_ex.illegal);
    assign commit  = act & ~id_ex.ebreak & ~id_ex.illegal;

    assign redirect.take   = commit & (taken | id_ex.jump);
    assign redirect.target = target;
    assign flush           = redirect.take | halting;

    assign wb.wen   = commit & id_ex.reg_wen;
    assign wb.waddr = id_ex.rd;
    assign wb.wdata = alu_res;

    // sd writes the full doubleword
    assign dmem_we    = commit & id_ex.store;
    assign dmem_addr  = alu_res;
    assign dmem_wdata = id_ex.rs2_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt    <= 1'b0;
            illegal <= 1'b0;
        end else if (halting) begin
            halt    <= 1'b1;             // sticky until reset
            illegal <= id_ex.illegal;
        end
    end

endmodule

//--- logic/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [ILEN-1:0] inst,
    output logic [XLEN-1:0] pc,
    output logic            dmem_we,
    output logic [XLEN-1:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    output logic            halt,
    output logic            illegal
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    wb_t       wb;
    redirect_t redirect;
    logic      flush;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .redirect (redirect),
        .flush    (flush),
        .halt     (halt),
        .pc       (pc),
        .if_id    (if_id)
    );

    decode_stage u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .if_id (if_id),
        .wb    (wb),
        .flush (flush),
        .id_ex (id_ex)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .wb         (wb),
        .redirect   (redirect),
        .flush      (flush),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .halt       (halt),
        .illegal    (illegal)
    );

endmodule

//--- tb/rv_core_properties.sv
`timescale 1ns/1ns

module rv_core_properties (
    input logic clk,
    input logic rst_n,
    input logic halt,
    input logic illegal,
    input logic dmem_we
);

    // sticky halt
    halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halt |=> halt
    ) else $error("halt fell without reset");

    illegal_halts: assert property (
        @(posedge clk) disable iff (!rst_n) illegal |-> halt
    ) else $error("illegal high while halt low");

    // no store once halted
    no_store_halted: assert property (
        @(posedge clk) disable iff (!rst_n) halt |-> !dmem_we
    ) else $error("dmem_we high while halted");

endmodule

bind rv_core_top rv_core_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .halt    (halt),
    .illegal (illegal),
    .dmem_we (dmem_we)
);

//--- tb/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb import rv_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC = 64'h1000;
    localparam int NUM = 7;
    localparam int WORDS = 10;
    localparam logic [31:0] EBRK = 32'h0010_0073;
    localparam int TIMEOUT = 200;

    logic clk, rst_n;
    logic [ILEN-1:0] inst;
    logic [XLEN-1:0] pc, dmem_addr, dmem_wdata;
    logic dmem_we, halt, illegal;

    logic [31:0] imem [WORDS];
    logic [31:0] prog [NUM][WORDS];
    logic [63:0] st_addr [NUM][4];
    logic [63:0] st_data [NUM][4];
    int st_n [NUM];
    logic ill [NUM];
    logic [31:0] seed;
    logic [63:0] idx;

    rv_core_top #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .halt(halt), .illegal(illegal)
    );

    assign idx = (pc - RESET_PC) >> 2;
    assign inst = (idx < WORDS) ? imem[idx[3:0]] : 32'h0; // off the end reads illegal

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3,
                                          int rd, logic [6:0] opc);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_sd(logic [11:0] imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_bne(logic [12:0] imm, int rs1, int rs2);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b001, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic add_store(int t, logic [63:0] a, logic [63:0] d);
        st_addr[t][st_n[t]] = a;
        st_data[t][st_n[t]] = d;
        st_n[t]++;
    endtask

    task automatic build_table();
        logic [11:0] ra, rb;
        logic [19:0] ru, rv;
        logic [63:0] a, b, u, v;
        for (int t = 0; t < NUM; t++) begin
            st_n[t] = 0;
            ill[t] = 1'b0;
            for (int w = 0; w < WORDS; w++) prog[t][w] = EBRK;
        end
        seed = xorshift(32'h963a);
        ra = seed[11:0];
        seed = xorshift(seed);
        rb = seed[11:0];
        seed = xorshift(seed);
        ru = seed[19:0];
        seed = xorshift(seed);
        rv = seed[19:0];
        a = {{52{ra[11]}}, ra};
        b = {{52{rb[11]}}, rb};
        u = {{32{ru[19]}}, ru, 12'b0};
        v = {{32{rv[19]}}, rv, 12'b0};
        // alu chain with back-to-back dependencies
        prog[0][0] = enc_i(ra, 0, 3'b000, 1, 7'b0010011);
        prog[0][1] = enc_i(rb, 1, 3'b000, 2, 7'b0010011);
        prog[0][2] = {ru, 5'd3, 7'b0110111};
        prog[0][3] = enc_r(7'b0000000, 4, 2, 3);
        prog[0][4] = enc_r(7'b0100000, 5, 4, 1);
        prog[0][5] = enc_sd(12'd8, 4, 0);
        prog[0][6] = enc_sd(12'd16, 5, 0);
        add_store(0, 64'd8, a + b + u);
        add_store(0, 64'd16, b + u);
        // bne taken skips two stores
        prog[1][0] = enc_i(12'd1, 0, 3'b000, 1, 7'b0010011);
        prog[1][1] = enc_bne(13'd12, 1, 0);
        prog[1][2] = enc_sd(12'd0, 1, 0);
        prog[1][3] = enc_sd(12'd8, 1, 0);
        prog[1][4] = enc_sd(12'd32, 1, 0);
        add_store(1, 64'd32, 64'd1);
        // bne not taken
        prog[2][0] = enc_i(12'd5, 0, 3'b000, 1, 7'b0010011);
        prog[2][1] = enc_bne(13'd12, 1, 1);
        prog[2][2] = enc_sd(12'd0, 1, 0);
        prog[2][3] = enc_sd(12'd8, 1, 0);
        add_store(2, 64'd0, 64'd5);
        add_store(2, 64'd8, 64'd5);
        // jalr to odd address, then jal over a store
        prog[3][0] = {20'd1, 5'd2, 7'b0110111};
        prog[3][1] = enc_i(12'd17, 2, 3'b000, 3, 7'b1100111);
        prog[3][2] = enc_sd(12'd0, 0, 0);
        prog[3][3] = EBRK;
        prog[3][4] = enc_jal(21'd8, 1);
        prog[3][5] = enc_sd(12'd8, 0, 0);
        prog[3][6] = enc_sd(12'd40, 1, 0);
        prog[3][7] = enc_sd(12'd48, 3, 0);
        add_store(3, 64'd40, RESET_PC + 64'd20);
        add_store(3, 64'd48, RESET_PC + 64'd8);
        // auipc, and no store after ebreak
        prog[4][0] = enc_i(12'd0, 0, 3'b000, 0, 7'b0010011);
        prog[4][1] = {rv, 5'd1, 7'b0010111};
        prog[4][2] = enc_sd(12'd56, 1, 0);
        prog[4][3] = EBRK;
        prog[4][4] = enc_sd(12'd0, 1, 0);
        add_store(4, 64'd56, RESET_PC + 64'd4 + v);
        // store opcode with sub-like funct7 and funct3 000
        prog[5][0] = enc_i(12'd7, 0, 3'b000, 1, 7'b0010011);
        prog[5][1] = enc_sd(12'd64, 1, 0);
        prog[5][2] = {7'b0100000, 5'd1, 5'd0, 3'b000, 5'd0, 7'b0100011};
        prog[5][3] = enc_sd(12'd72, 1, 0);
        add_store(5, 64'd64, 64'd7);
        ill[5] = 1'b1;
        // load opcode is unsupported
        prog[6][0] = {ru, 5'd1, 7'b0110111};
        prog[6][1] = 32'h0000_3083;
        prog[6][2] = enc_sd(12'd0, 1, 0);
        ill[6] = 1'b1;
    endtask

    initial begin
        int cnt;
        int cyc;
        rst_n = 1'b0;
        build_table();
        for (int t = 0; t < NUM; t++) begin
            for (int w = 0; w < WORDS; w++) imem[w] = prog[t][w];
            @(negedge clk);
            rst_n = 1'b0;
            repeat (16) @(negedge clk);
            assert (pc == RESET_PC) else
                stop_on_error($sformatf("Fail pc got %h expected %h", pc, RESET_PC));
            assert (!halt && !illegal && !dmem_we) else
                stop_on_error($sformatf("entry %0d status outputs high during reset", t));
            rst_n = 1'b1;
            cnt = 0;
            cyc = 0;
            while (!halt) begin
                if (cyc >= TIMEOUT) stop_on_error($sformatf("entry %0d never halted", t));
                if (dmem_we) begin
                    assert (cnt < st_n[t]) else
                        stop_on_error($sformatf("entry %0d extra store", t));
                    assert (dmem_addr == st_addr[t][cnt]) else
                        stop_on_error($sformatf("Fail dmem_addr got %h expected %h",
                                                dmem_addr, st_addr[t][cnt]));
                    assert (dmem_wdata == st_data[t][cnt]) else
                        stop_on_error($sformatf("Fail dmem_wdata got %h expected %h",
                                                dmem_wdata, st_data[t][cnt]));
                    cnt++;
                end
                @(negedge clk);
                cyc++;
            end
            assert (cnt == st_n[t]) else
                stop_on_error($sformatf("entry %0d missing stores, saw %0d", t, cnt));
            assert (illegal == ill[t]) else
                stop_on_error($sformatf("Fail illegal got %h expected %h", illegal, ill[t]));
            repeat (4) @(negedge clk);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- flist.f
logic/rv_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv_core_top.sv
tb/rv_core_properties.sv
tb/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
